//--- compile.f
hdl/rob_pkg.sv
hdl/order_cell.sv
hdl/cell_array.sv
hdl/slot_alloc.sv
hdl/qos_vote.sv
hdl/payload_store.sv
hdl/output_stage.sv
hdl/reorder_buffer.sv
dv/tb_reorder_buffer.sv

//--- dv/tb_reorder_buffer.sv
`timescale 1ns/1ps

module tb_reorder_buffer;

    localparam int NUM_CELLS = 24;
    localparam int PAYLOAD_W = 128;
    localparam int RESET_LEN = 3;
    localparam int RAND_LEN  = 400;
    localparam int QOS_LEN   = 10 * 2;
    localparam int FULL_LEN  = NUM_CELLS * 2;
    localparam int DRAIN_LEN = NUM_CELLS * 3;
    // three drains in total
    localparam int TIMEOUT   = 2 * (RESET_LEN + RAND_LEN + QOS_LEN + FULL_LEN + 3 * DRAIN_LEN);

    logic                  clk;
    logic                  rst_n;
    logic                  i_valid_a;
    logic                  i_valid_b;
    rob_pkg::src_id_t      i_id_a;
    rob_pkg::src_id_t      i_id_b;
    rob_pkg::qos_t         i_qos_a;
    rob_pkg::qos_t         i_qos_b;
    logic [PAYLOAD_W-1:0]  i_payload_a;
    logic [PAYLOAD_W-1:0]  i_payload_b;
    logic                  i_ready_c;
    logic                  o_ready_a;
    logic                  o_ready_b;
    logic                  o_valid_c;
    rob_pkg::flit_id_t     o_id_c;
    rob_pkg::qos_t         o_qos_c;
    logic [PAYLOAD_W-1:0]  o_payload_c;

    // one queue of {qos, payload} entries per flit id
    logic [PAYLOAD_W+1:0]  pend_q [64][$];
    integer                seed = 86;
    int                    errors;
    int                    checks;
    int                    accepted;
    int                    departed;
    int                    cycles;
    int                    qos_deps;
    int                    full_start;
    logic                  qos_check;
    logic                  took_a;
    logic                  took_b;
    logic                  prev_stall;
    rob_pkg::flit_id_t     prev_id;
    rob_pkg::qos_t         prev_qos;
    logic [PAYLOAD_W-1:0]  prev_payload;

    reorder_buffer #(.NUM_CELLS(NUM_CELLS), .PAYLOAD_W(PAYLOAD_W)) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (i_valid_a),
        .i_valid_b   (i_valid_b),
        .i_id_a      (i_id_a),
        .i_id_b      (i_id_b),
        .i_qos_a     (i_qos_a),
        .i_qos_b     (i_qos_b),
        .i_payload_a (i_payload_a),
        .i_payload_b (i_payload_b),
        .i_ready_c   (i_ready_c),
        .o_ready_a   (o_ready_a),
        .o_ready_b   (o_ready_b),
        .o_valid_c   (o_valid_c),
        .o_id_c      (o_id_c),
        .o_qos_c     (o_qos_c),
        .o_payload_c (o_payload_c)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [PAYLOAD_W-1:0] got,
                             input logic [PAYLOAD_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    function automatic logic [PAYLOAD_W-1:0] rand_payload();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic rob_pkg::qos_t max_pending_qos();
        rob_pkg::qos_t best;
        best = '0;
        for (int f = 0; f < 64; f++) begin
            for (int k = 0; k < pend_q[f].size(); k++) begin
                if (pend_q[f][k][PAYLOAD_W+1:PAYLOAD_W] > best) begin
                    best = pend_q[f][k][PAYLOAD_W+1:PAYLOAD_W];
                end
            end
        end
        return best;
    endfunction

    // new flit only once the previous one was taken
    task automatic drive_inputs(input logic want_a, input logic want_b, input int id_range);
        if (!i_valid_a || took_a) begin
            i_valid_a   = want_a;
            i_id_a      = rob_pkg::src_id_t'({$random(seed)} % id_range);
            i_qos_a     = rob_pkg::qos_t'($random(seed));
            i_payload_a = rand_payload();
        end
        if (!i_valid_b || took_b) begin
            i_valid_b   = want_b;
            i_id_b      = rob_pkg::src_id_t'({$random(seed)} % id_range);
            i_qos_b     = rob_pkg::qos_t'($random(seed));
            i_payload_b = rand_payload();
        end
    endtask

    task automatic send_a(input rob_pkg::src_id_t id, input rob_pkg::qos_t qos);
        i_valid_a   = 1'b1;
        i_id_a      = id;
        i_qos_a     = qos;
        i_payload_a = rand_payload();
        do begin
            @(negedge clk);
        end while (!took_a);
        i_valid_a = 1'b0;
    endtask

    task automatic drain_all();
        i_ready_c = 1'b1;
        do begin
            drive_inputs(1'b0, 1'b0, 1);
            @(negedge clk);
        end while (i_valid_a || i_valid_b || o_valid_c || accepted != departed);
    endtask

    always @(posedge clk) begin : monitor
        logic [PAYLOAD_W+1:0] head;
        if (rst_n) begin
            took_a = i_valid_a && o_ready_a;
            took_b = i_valid_b && o_ready_b;
            // stalled last edge, so port C must not have moved
            if (prev_stall) begin
                check_val("o_valid_c", o_valid_c, 1'b1);
                check_val("o_id_c", o_id_c, prev_id);
                check_val("o_qos_c", o_qos_c, prev_qos);
                check_val("o_payload_c", o_payload_c, prev_payload);
            end
            if (o_valid_c && i_ready_c) begin
                if (qos_check && qos_deps > 0) begin
                    check_val("o_qos_c (priority)", o_qos_c, max_pending_qos());
                end
                assert (pend_q[o_id_c].size() > 0) else begin
                    errors++;
                    $display("Port C returned flit id %0h at %0d ns with none pending",
                             o_id_c, $time);
                end
                if (pend_q[o_id_c].size() > 0) begin
                    head = pend_q[o_id_c].pop_front();
                    check_val("o_qos_c", o_qos_c, head[PAYLOAD_W+1:PAYLOAD_W]);
                    check_val("o_payload_c", o_payload_c, head[PAYLOAD_W-1:0]);
                end
                departed++;
                if (qos_check) begin
                    qos_deps++;
                end
            end
            if (took_a) begin
                pend_q[{1'b0, i_id_a}].push_back({i_qos_a, i_payload_a});
                accepted++;
            end
            if (took_b) begin
                pend_q[{1'b1, i_id_b}].push_back({i_qos_b, i_payload_b});
                accepted++;
            end
            prev_stall   = o_valid_c && !i_ready_c;
            prev_id      = o_id_c;
            prev_qos     = o_qos_c;
            prev_payload = o_payload_c;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        i_valid_a   = 1'b0;
        i_valid_b   = 1'b0;
        i_id_a      = '0;
        i_id_b      = '0;
        i_qos_a     = '0;
        i_qos_b     = '0;
        i_payload_a = '0;
        i_payload_b = '0;
        i_ready_c   = 1'b0;
        took_a      = 1'b0;
        took_b      = 1'b0;
        prev_stall  = 1'b0;
        qos_check   = 1'b0;

        @(negedge clk);
        check_val("o_valid_c", o_valid_c, 1'b0);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("o_valid_c", o_valid_c, 1'b0);
        check_val("o_ready_a", o_ready_a, 1'b1);
        check_val("o_ready_b", o_ready_b, 1'b1);

        // mixed traffic with few ids so same-id order gets exercised
        repeat (RAND_LEN) begin
            drive_inputs(1'($random(seed)), 1'($random(seed)), 4);
            i_ready_c = ({$random(seed)} % 4) != 0;
            @(negedge clk);
        end
        drain_all();

        // stack ten distinct ids behind a stalled port C
        i_ready_c = 1'b0;
        for (int i = 0; i < 10; i++) begin
            send_a(rob_pkg::src_id_t'(i), rob_pkg::qos_t'($random(seed)));
        end
        qos_deps  = 0;
        qos_check = 1'b1;
        drain_all();
        qos_check = 1'b0;

        // fill the whole pool with port C stalled
        i_ready_c  = 1'b0;
        full_start = accepted;
        while (accepted - full_start < NUM_CELLS) begin
            drive_inputs(1'b1, 1'b1, 32);
            @(negedge clk);
        end
        check_val("o_ready_a", o_ready_a, 1'b0);
        check_val("o_ready_b", o_ready_b, 1'b0);
        repeat (2) @(negedge clk);
        check_val("o_ready_a", o_ready_a, 1'b0);
        check_val("o_ready_b", o_ready_b, 1'b0);
        drain_all();

        assert (accepted == departed) else begin
            errors++;
            $display("Flits lost: %0d accepted but %0d returned", accepted, departed);
        end
        $display("Checks: %0d, errors: %0d, flits accepted: %0d, flits returned: %0d",
                 checks, errors, accepted, departed);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/cell_array.sv
`timescale 1ns/1ps

module cell_array #(
    parameter int NUM_CELLS = 24
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_CELLS-1:0]  i_wr_sel_a,
    input  logic [NUM_CELLS-1:0]  i_wr_sel_b,
    input  rob_pkg::src_id_t      i_id_a,
    input  rob_pkg::src_id_t      i_id_b,
    input  rob_pkg::qos_t         i_qos_a,
    input  rob_pkg::qos_t         i_qos_b,
    input  logic [NUM_CELLS-1:0]  i_claim_sel,
    input  logic [NUM_CELLS-1:0]  i_depart_sel,
    input  rob_pkg::flit_id_t     i_depart_id,
    output logic [NUM_CELLS-1:0]  o_valid_vec,
    output logic [NUM_CELLS-1:0]  o_eligible_vec,
    output rob_pkg::qos_onehot_t  o_qos_onehot [NUM_CELLS],
    output rob_pkg::flit_id_t     o_flit_id [NUM_CELLS]
);

    rob_pkg::flit_id_t     fid_a;
    rob_pkg::flit_id_t     fid_b;
    rob_pkg::seq_cnt_t     rank [NUM_CELLS];
    rob_pkg::seq_cnt_t     tail_rank_a;
    rob_pkg::seq_cnt_t     tail_rank_b;
    logic [NUM_CELLS-1:0]  tail;
    logic [NUM_CELLS-1:0]  match_a;
    logic [NUM_CELLS-1:0]  match_b;
    logic [NUM_CELLS-1:0]  found;
    logic                  depart_any;

    assign fid_a      = {1'b0, i_id_a};
    assign fid_b      = {1'b1, i_id_b};
    assign depart_any = |i_depart_sel;

    // tail of each incoming id where a departing tail counts as no older flit
    always_comb begin
        for (int i = 0; i < NUM_CELLS; i++) begin
            match_a[i] = o_valid_vec[i] & tail[i] & ~i_depart_sel[i] & (o_flit_id[i] == fid_a);
            match_b[i] = o_valid_vec[i] & tail[i] & ~i_depart_sel[i] & (o_flit_id[i] == fid_b);
            found[i]   = (i_wr_sel_a[i] & (|match_a)) | (i_wr_sel_b[i] & (|match_b)) |
                         (match_a[i] & (|i_wr_sel_a)) | (match_b[i] & (|i_wr_sel_b));
        end
    end

    always_comb begin
        rob_pkg::seq_cnt_t or_a;
        rob_pkg::seq_cnt_t or_b;
        or_a = '0;
        or_b = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            or_a = or_a | (rank[i] & {$bits(rob_pkg::seq_cnt_t){match_a[i]}});
            or_b = or_b | (rank[i] & {$bits(rob_pkg::seq_cnt_t){match_b[i]}});
        end
        // the tail steps down in the same edge as a same-id departure
        tail_rank_a = or_a - ((depart_any && (i_depart_id == fid_a)) ? 1'b1 : 1'b0);
        tail_rank_b = or_b - ((depart_any && (i_depart_id == fid_b)) ? 1'b1 : 1'b0);
    end

    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        order_cell u_cell (
            .clk          (clk),
            .rst_n        (rst_n),
            .i_write      (i_wr_sel_a[i] | i_wr_sel_b[i]),
            .i_flit_id    (i_wr_sel_b[i] ? fid_b : fid_a),
            .i_qos        (i_wr_sel_b[i] ? i_qos_b : i_qos_a),
            .i_tail_rank  (i_wr_sel_b[i] ? tail_rank_b : tail_rank_a),
            .i_tail_found (found[i]),
            .i_claim      (i_claim_sel[i]),
            .i_depart     (depart_any),
            .i_depart_id  (i_depart_id),
            .o_valid      (o_valid_vec[i]),
            .o_flit_id    (o_flit_id[i]),
            .o_qos_onehot (o_qos_onehot[i]),
            .o_rank       (rank[i]),
            .o_tail       (tail[i]),
            .o_eligible   (o_eligible_vec[i])
        );
    end

endmodule

//--- hdl/order_cell.sv
`timescale 1ns/1ps

module order_cell (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_write,
    input  rob_pkg::flit_id_t     i_flit_id,
    input  rob_pkg::qos_t         i_qos,
    input  rob_pkg::seq_cnt_t     i_tail_rank,
    input  logic                  i_tail_found,
    input  logic                  i_claim,
    input  logic                  i_depart,
    input  rob_pkg::flit_id_t     i_depart_id,
    output logic                  o_valid,
    output rob_pkg::flit_id_t     o_flit_id,
    output rob_pkg::qos_onehot_t  o_qos_onehot,
    output rob_pkg::seq_cnt_t     o_rank,
    output logic                  o_tail,
    output logic                  o_eligible
);

    logic           claimed;
    rob_pkg::qos_t  qos;
    logic           own_depart;
    logic           same_id_depart;

    // only the cell sitting in the output register is claimed
    assign own_depart     = i_depart & o_valid & claimed;
    assign same_id_depart = i_depart & o_valid & (o_flit_id == i_depart_id);

    // on a write i_tail_found means an older same-id flit exists
    // otherwise it means this tail was just superseded by a newer flit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            claimed <= 1'b0;
            o_tail  <= 1'b0;
            o_rank  <= '0;
        end else if (i_write) begin
            o_valid <= 1'b1;
            claimed <= 1'b0;
            o_tail  <= 1'b1;
            o_rank  <= i_tail_found ? i_tail_rank + 1'b1 : '0;
        end else if (own_depart) begin
            o_valid <= 1'b0;
            claimed <= 1'b0;
            o_tail  <= 1'b0;
            o_rank  <= '0;
        end else begin
            if (i_claim) begin
                claimed <= 1'b1;
            end
            if (i_tail_found) begin
                o_tail <= 1'b0;
            end
            // move up one when the head of this id leaves
            if (same_id_depart) begin
                o_rank <= o_rank - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_write) begin
            o_flit_id <= i_flit_id;
            qos       <= i_qos;
        end
    end

    assign o_qos_onehot = rob_pkg::qos_onehot_t'(4'b0001 << qos);
    assign o_eligible   = o_valid & ~claimed & (o_rank == '0);

endmodule

//--- hdl/output_stage.sv
`timescale 1ns/1ps

module output_stage #(
    parameter int NUM_CELLS = 24,
    parameter int PAYLOAD_W = 128
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_CELLS-1:0]  i_pick,
    input  logic                  i_pick_valid,
    input  rob_pkg::flit_id_t     i_pick_id,
    input  rob_pkg::qos_t         i_pick_qos,
    input  logic [PAYLOAD_W-1:0]  i_pick_payload,
    input  logic                  i_ready_c,
    output logic                  o_valid_c,
    output rob_pkg::flit_id_t     o_id_c,
    output rob_pkg::qos_t         o_qos_c,
    output logic [PAYLOAD_W-1:0]  o_payload_c,
    output logic [NUM_CELLS-1:0]  o_claim_sel,
    output logic [NUM_CELLS-1:0]  o_depart_sel
);

    logic [NUM_CELLS-1:0]  held_sel;   // cell behind the flit on port C
    logic                  depart;
    logic                  load;

    assign depart = o_valid_c & i_ready_c;
    // register empty or emptying this edge
    assign load   = i_pick_valid & (~o_valid_c | i_ready_c);

    assign o_claim_sel  = i_pick & {NUM_CELLS{load}};
    assign o_depart_sel = held_sel & {NUM_CELLS{depart}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid_c <= 1'b0;
            held_sel  <= '0;
        end else if (load) begin
            o_valid_c <= 1'b1;
            held_sel  <= i_pick;
        end else if (depart) begin
            o_valid_c <= 1'b0;
            held_sel  <= '0;
        end
    end

    // held under back-pressure since load needs a free register
    always_ff @(posedge clk) begin
        if (load) begin
            o_id_c      <= i_pick_id;
            o_qos_c     <= i_pick_qos;
            o_payload_c <= i_pick_payload;
        end
    end

endmodule

//--- hdl/payload_store.sv
`timescale 1ns/1ps

module payload_store #(
    parameter int NUM_CELLS = 24,
    parameter int PAYLOAD_W = 128
) (
    input  logic                  clk,
    input  logic [NUM_CELLS-1:0]  i_wr_sel_a,
    input  logic [NUM_CELLS-1:0]  i_wr_sel_b,
    input  logic [PAYLOAD_W-1:0]  i_payload_a,
    input  logic [PAYLOAD_W-1:0]  i_payload_b,
    input  logic [NUM_CELLS-1:0]  i_rd_sel,
    output logic [PAYLOAD_W-1:0]  o_rd_payload
);

    logic [PAYLOAD_W-1:0] mem [NUM_CELLS];

    // A and B never select the same cell
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (i_wr_sel_a[i]) begin
                mem[i] <= i_payload_a;
            end else if (i_wr_sel_b[i]) begin
                mem[i] <= i_payload_b;
            end
        end
    end

    always_comb begin
        o_rd_payload = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            o_rd_payload = o_rd_payload | (mem[i] & {PAYLOAD_W{i_rd_sel[i]}});
        end
    end

endmodule

//--- hdl/qos_vote.sv
`timescale 1ns/1ps

module qos_vote #(
    parameter int NUM_CELLS = 24
) (
    input  logic [NUM_CELLS-1:0]  i_eligible_vec,
    input  rob_pkg::qos_onehot_t  i_qos_onehot [NUM_CELLS],
    output logic [NUM_CELLS-1:0]  o_pick,
    output logic                  o_pick_valid
);

    rob_pkg::qos_onehot_t  qos_seen;
    rob_pkg::qos_onehot_t  qos_top;
    logic [NUM_CELLS-1:0]  cand;

    always_comb begin
        qos_seen = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (i_eligible_vec[i]) begin
                qos_seen = qos_seen | i_qos_onehot[i];
            end
        end
    end

    // keep only the highest qos present
    always_comb begin
        qos_top = '0;
        for (int q = 0; q < $bits(rob_pkg::qos_onehot_t); q++) begin
            if (qos_seen[q]) begin
                qos_top    = '0;
                qos_top[q] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CELLS; i++) begin
            cand[i] = i_eligible_vec[i] & (|(i_qos_onehot[i] & qos_top));
        end
    end

    // lowest index among the winners
    assign o_pick       = cand & (~cand + 1'b1);
    assign o_pick_valid = |i_eligible_vec;

endmodule

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int NUM_CELLS = 24,
    parameter int PAYLOAD_W = 128
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_valid_a,
    input  logic                  i_valid_b,
    input  rob_pkg::src_id_t      i_id_a,
    input  rob_pkg::src_id_t      i_id_b,
    input  rob_pkg::qos_t         i_qos_a,
    input  rob_pkg::qos_t         i_qos_b,
    input  logic [PAYLOAD_W-1:0]  i_payload_a,
    input  logic [PAYLOAD_W-1:0]  i_payload_b,
    input  logic                  i_ready_c,
    output logic                  o_ready_a,
    output logic                  o_ready_b,
    output logic                  o_valid_c,
    output rob_pkg::flit_id_t     o_id_c,
    output rob_pkg::qos_t         o_qos_c,
    output logic [PAYLOAD_W-1:0]  o_payload_c
);

    logic [NUM_CELLS-1:0]  wr_sel_a;
    logic [NUM_CELLS-1:0]  wr_sel_b;
    logic [NUM_CELLS-1:0]  valid_vec;
    logic [NUM_CELLS-1:0]  eligible_vec;
    logic [NUM_CELLS-1:0]  pick;
    logic [NUM_CELLS-1:0]  claim_sel;
    logic [NUM_CELLS-1:0]  depart_sel;
    logic                  pick_valid;
    rob_pkg::qos_onehot_t  qos_onehot [NUM_CELLS];
    rob_pkg::flit_id_t     flit_id [NUM_CELLS];
    rob_pkg::flit_id_t     pick_id;
    rob_pkg::qos_t         pick_qos;
    logic [PAYLOAD_W-1:0]  pick_payload;

    // id and qos of the picked cell
    always_comb begin
        rob_pkg::qos_onehot_t pick_oh;
        pick_oh = '0;
        pick_id = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            pick_id = pick_id | (flit_id[i] & {$bits(rob_pkg::flit_id_t){pick[i]}});
            pick_oh = pick_oh | (qos_onehot[i] & {$bits(rob_pkg::qos_onehot_t){pick[i]}});
        end
        pick_qos = {pick_oh[3] | pick_oh[2], pick_oh[3] | pick_oh[1]};
    end

    slot_alloc #(.NUM_CELLS(NUM_CELLS)) u_slot_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (i_valid_a),
        .i_valid_b   (i_valid_b),
        .i_valid_vec (valid_vec),
        .o_ready_a   (o_ready_a),
        .o_ready_b   (o_ready_b),
        .o_wr_sel_a  (wr_sel_a),
        .o_wr_sel_b  (wr_sel_b)
    );

    cell_array #(.NUM_CELLS(NUM_CELLS)) u_cell_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_wr_sel_a     (wr_sel_a),
        .i_wr_sel_b     (wr_sel_b),
        .i_id_a         (i_id_a),
        .i_id_b         (i_id_b),
        .i_qos_a        (i_qos_a),
        .i_qos_b        (i_qos_b),
        .i_claim_sel    (claim_sel),
        .i_depart_sel   (depart_sel),
        .i_depart_id    (o_id_c),
        .o_valid_vec    (valid_vec),
        .o_eligible_vec (eligible_vec),
        .o_qos_onehot   (qos_onehot),
        .o_flit_id      (flit_id)
    );

    qos_vote #(.NUM_CELLS(NUM_CELLS)) u_qos_vote (
        .i_eligible_vec (eligible_vec),
        .i_qos_onehot   (qos_onehot),
        .o_pick         (pick),
        .o_pick_valid   (pick_valid)
    );

    payload_store #(.NUM_CELLS(NUM_CELLS), .PAYLOAD_W(PAYLOAD_W)) u_payload_store (
        .clk          (clk),
        .i_wr_sel_a   (wr_sel_a),
        .i_wr_sel_b   (wr_sel_b),
        .i_payload_a  (i_payload_a),
        .i_payload_b  (i_payload_b),
        .i_rd_sel     (pick),
        .o_rd_payload (pick_payload)
    );

    output_stage #(.NUM_CELLS(NUM_CELLS), .PAYLOAD_W(PAYLOAD_W)) u_output_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_pick         (pick),
        .i_pick_valid   (pick_valid),
        .i_pick_id      (pick_id),
        .i_pick_qos     (pick_qos),
        .i_pick_payload (pick_payload),
        .i_ready_c      (i_ready_c),
        .o_valid_c      (o_valid_c),
        .o_id_c         (o_id_c),
        .o_qos_c        (o_qos_c),
        .o_payload_c    (o_payload_c),
        .o_claim_sel    (claim_sel),
        .o_depart_sel   (depart_sel)
    );

endmodule

//--- hdl/rob_pkg.sv
package rob_pkg;

    // id as driven at ports A and B
    typedef logic [4:0] src_id_t;

    // port bit on top, then src_id_t
    // flits keep their order per flit id
    typedef logic [5:0] flit_id_t;

    // larger value wins at port C
    typedef logic [1:0] qos_t;

    // bit n set for qos n
    typedef logic [3:0] qos_onehot_t;

    // counts older flits of the same flit id over the whole pool
    typedef logic [4:0] seq_cnt_t;

endpackage

//--- hdl/slot_alloc.sv
`timescale 1ns/1ps

module slot_alloc #(
    parameter int NUM_CELLS = 24
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_valid_a,
    input  logic                  i_valid_b,
    input  logic [NUM_CELLS-1:0]  i_valid_vec,
    output logic                  o_ready_a,
    output logic                  o_ready_b,
    output logic [NUM_CELLS-1:0]  o_wr_sel_a,
    output logic [NUM_CELLS-1:0]  o_wr_sel_b
);

    localparam int CNT_W = $clog2(NUM_CELLS + 1);

    logic [NUM_CELLS-1:0]  free_vec;
    logic [NUM_CELLS-1:0]  low_free;
    logic [NUM_CELLS-1:0]  high_free;
    logic [CNT_W-1:0]      free_cnt;
    logic [CNT_W-1:0]      remain;
    logic                  acc_a;
    logic                  acc_b;
    logic                  one_slot;
    logic                  turn;        // lone cell goes to A when 0, to B when 1
    logic                  turn_next;

    assign free_vec = ~i_valid_vec;
    assign low_free = free_vec & (~free_vec + 1'b1);

    always_comb begin
        high_free = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (free_vec[i]) begin
                high_free    = '0;
                high_free[i] = 1'b1;
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            free_cnt = free_cnt + CNT_W'(free_vec[i]);
        end
    end

    assign acc_a      = i_valid_a & o_ready_a;
    assign acc_b      = i_valid_b & o_ready_b;
    assign o_wr_sel_a = low_free & {NUM_CELLS{acc_a}};
    assign o_wr_sel_b = high_free & {NUM_CELLS{acc_b}};

    // departures of this cycle show up in i_valid_vec one edge later
    assign remain   = free_cnt - CNT_W'(acc_a) - CNT_W'(acc_b);
    assign one_slot = o_ready_a ^ o_ready_b;

    // hand the lone cell over once taken, or when only the other port wants it
    always_comb begin
        turn_next = turn;
        if (one_slot) begin
            if (!turn && (acc_a || (!i_valid_a && i_valid_b))) begin
                turn_next = 1'b1;
            end else if (turn && (acc_b || (!i_valid_b && i_valid_a))) begin
                turn_next = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            turn      <= 1'b0;
            o_ready_a <= 1'b1;
            o_ready_b <= 1'b1;
        end else begin
            turn      <= turn_next;
            o_ready_a <= (remain > 1) | ((remain == 1) & ~turn_next);
            o_ready_b <= (remain > 1) | ((remain == 1) & turn_next);
        end
    end

endmodule
